/* compile.f */
tq_task_pkg.sv
tq_ctrl_pkg.sv
tq_cfg_regs.sv
tq_insert_stage.sv
tq_task_store.sv
tq_spill_counter.sv
tq_op_sched.sv
tq_deq_gate.sv
tq_spill_fifo.sv
task_unit.sv
tb_task_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the task unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_task_unit -Mdir "$OBJ" -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_task_unit" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
   echo "Result: passed"
   exit 0
fi
echo "Result: failed"
exit 1

/* task_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module task_unit (
   input  wire                                     clk,
   input  wire                                     rstn,
   input  wire                                     task_enq_valid,
   output logic                                    task_enq_ready,
   input  wire tq_task_pkg::task_t                 task_enq_data,
   input  wire                                     coal_child_valid,
   output logic                                    coal_child_ready,
   input  wire tq_task_pkg::task_t                 coal_child_data,
   output logic                                    task_deq_valid,
   input  wire                                     task_deq_ready,
   output tq_task_pkg::task_t                      task_deq_data,
   output logic                                    splitter_deq_valid,
   input  wire                                     splitter_deq_ready,
   output tq_task_pkg::task_t                      splitter_deq_task,
   output logic                                    overflow_valid,
   input  wire                                     overflow_ready,
   output tq_task_pkg::task_t                      overflow_data,
   input  wire                                     cfg_wvalid,
   input  wire [tq_ctrl_pkg::CFG_ADDR_WIDTH-1:0]   cfg_waddr,
   input  wire [31:0]                              cfg_wdata,
   input  wire tq_task_pkg::ts_t                   gvt_ts,
   output logic                                    full,
   output logic                                    almost_full,
   output logic                                    empty,
   output tq_task_pkg::ts_t                        lvt
);
   import tq_task_pkg::*;
   import tq_ctrl_pkg::*;

   logic [CNT_WIDTH-1:0] spill_threshold;
   logic [CNT_WIDTH-1:0] spill_size;
   ts_t                  throttle_margin;
   logic                 started;

   logic                 ins_valid;
   task_t                ins_task;
   logic                 ins_clear;
   heap_op_t             store_op;
   task_t                head_task;
   task_t                max_task;
   logic                 head_valid;
   logic [CNT_WIDTH-1:0] n_tasks;
   logic                 spilling;
   logic                 deq_fire;
   logic [CNT_WIDTH-1:0] fifo_count;
   logic                 spill_wr_en;

   // Tail leaves the store and enters the FIFO on the same edge
   assign spill_wr_en = (store_op == DEQ_MAX);

   tq_cfg_regs u_cfg (
      .clk, .rstn, .cfg_wvalid, .cfg_waddr, .cfg_wdata,
      .spill_threshold, .spill_size, .throttle_margin, .started
   );

   tq_insert_stage u_insert (
      .clk, .rstn,
      .coal_child_valid, .coal_child_data, .coal_child_ready,
      .task_enq_valid, .task_enq_data, .task_enq_ready,
      .spilling, .ins_clear, .ins_valid, .ins_task
   );

   tq_task_store u_store (
      .clk, .rstn, .store_op, .ins_task,
      .head_task, .max_task, .head_valid, .n_tasks, .full, .empty
   );

   tq_spill_counter u_spill_cnt (
      .clk, .rstn, .store_op, .n_tasks,
      .spill_threshold, .spill_size, .almost_full, .spilling
   );

   tq_op_sched u_sched (
      .clk, .rstn, .spilling, .ins_valid, .deq_fire, .empty, .full,
      .fifo_count, .store_op, .ins_clear
   );

   tq_deq_gate u_deq (
      .clk, .rstn, .head_task, .head_valid, .started, .spilling,
      .gvt_ts, .throttle_margin, .task_deq_ready, .splitter_deq_ready,
      .task_deq_valid, .splitter_deq_valid, .task_deq_data, .splitter_deq_task,
      .deq_fire, .lvt
   );

   tq_spill_fifo u_spill_fifo (
      .clk, .rstn, .wr_en(spill_wr_en), .wr_data(max_task),
      .overflow_ready, .overflow_valid, .overflow_data, .fifo_count
   );

endmodule

`default_nettype wire

/* tb_task_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_task_unit;
   import tq_task_pkg::*;
   import tq_ctrl_pkg::*;

   localparam int SEED = 6744;
   localparam int STIM_CYCLES = 3000;
   // Drain needs a few dozen cycles, the rest is slack
   localparam int DRAIN_CYCLES = 1000;
   localparam int TIMEOUT_CYCLES = STIM_CYCLES + DRAIN_CYCLES;
   localparam int START_CYCLE = 20;

   typedef struct packed {
      logic  settled;
      task_t t;
   } entry_t;

   logic                      clk;
   logic                      rstn;
   logic                      task_enq_valid;
   logic                      task_enq_ready;
   task_t                     task_enq_data;
   logic                      coal_child_valid;
   logic                      coal_child_ready;
   task_t                     coal_child_data;
   logic                      task_deq_valid;
   logic                      task_deq_ready;
   task_t                     task_deq_data;
   logic                      splitter_deq_valid;
   logic                      splitter_deq_ready;
   task_t                     splitter_deq_task;
   logic                      overflow_valid;
   logic                      overflow_ready;
   task_t                     overflow_data;
   logic                      cfg_wvalid;
   logic [CFG_ADDR_WIDTH-1:0] cfg_waddr;
   logic [31:0]               cfg_wdata;
   ts_t                       gvt_ts;
   logic                      full;
   logic                      almost_full;
   logic                      empty;
   ts_t                       lvt;

   // Accepted tasks in arrival order
   entry_t model [$];
   int     accepted;
   int     removed;
   int     errors;
   int     cycles;
   int     seed_val;
   int     idx;
   int     threshold_m;
   logic   started_m;
   ts_t    margin_m;
   ts_t    prev_margin;
   ts_t    prev_gvt;
   logic   armed;
   logic   any_ready;
   logic   all_settled;

   task_unit DUT (
      .clk, .rstn,
      .task_enq_valid, .task_enq_ready, .task_enq_data,
      .coal_child_valid, .coal_child_ready, .coal_child_data,
      .task_deq_valid, .task_deq_ready, .task_deq_data,
      .splitter_deq_valid, .splitter_deq_ready, .splitter_deq_task,
      .overflow_valid, .overflow_ready, .overflow_data,
      .cfg_wvalid, .cfg_waddr, .cfg_wdata, .gvt_ts,
      .full, .almost_full, .empty, .lvt
   );

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
      if (actual !== expected) begin
         errors++;
         $display("FAIL %0t ns: %s (got %0d, expected %0d)", $time, what, actual, expected);
         $display("=== FAIL ===");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   function automatic task_t rand_task();
      task_t t;
      t.ts     = ts_t'($urandom % 256);
      t.ttype  = ttype_t'($urandom % 16);
      t.locale = $urandom;
      t.args   = $urandom;
      return t;
   endfunction

   function automatic int find_task(input task_t t);
      int found;
      found = -1;
      for (int i = 0; i < model.size(); i++) begin
         if (found < 0 && model[i].t == t) begin
            found = i;
         end
      end
      return found;
   endfunction

   function automatic logic settled_all();
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < model.size(); i++) begin
         if (!model[i].settled) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   function automatic logic has_earlier_settled(input ts_t ts);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < model.size(); i++) begin
         if (model[i].settled && model[i].t.ts < ts) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   // All ones when nothing waits
   function automatic ts_t min_ts();
      ts_t m;
      m = '1;
      for (int i = 0; i < model.size(); i++) begin
         if (model[i].t.ts < m) begin
            m = model[i].t.ts;
         end
      end
      return m;
   endfunction

   // Tasks older than a spilled one were in the store when it was spilled
   function automatic logic older_task_later(input int pos, input ts_t ts);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < pos; i++) begin
         if (model[i].t.ts > ts) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   task automatic mark_settled();
      entry_t e;
      for (int i = 0; i < model.size(); i++) begin
         e = model[i];
         e.settled = 1'b1;
         model[i] = e;
      end
   endtask

   task automatic take_task(input task_t t, input string port);
      int pos;
      pos = find_task(t);
      check_eq(32'(pos >= 0), 32'd1, {port, " delivered a task that was never accepted"});
      model.delete(pos);
      removed++;
   endtask

   // Called 1 ns after a rising edge, holds the strobe for one cycle
   task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
      cfg_wvalid = 1'b1;
      cfg_waddr  = addr;
      cfg_wdata  = data;
      @(posedge clk);
      #1;
      cfg_wvalid = 1'b0;
   endtask

   task automatic drive_cycle(input int cyc);
      coal_child_valid   = ($urandom % 4) == 0;
      coal_child_data    = rand_task();
      task_enq_valid     = ($urandom % 2) == 0;
      task_enq_data      = rand_task();
      task_deq_ready     = ($urandom % 5) < 3;
      splitter_deq_ready = ($urandom % 2) == 0;
      overflow_ready     = ($urandom % 5) < 3;
      cfg_wvalid         = 1'b0;
      if (($urandom % 32) == 0) begin
         gvt_ts = gvt_ts + 32'd1 + ($urandom % 2);
      end
      if (cyc == START_CYCLE) begin
         cfg_wvalid = 1'b1;
         cfg_waddr  = CFG_START;
         cfg_wdata  = 32'd1;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not drain within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
   end

   initial begin
      seed_val           = $urandom(SEED);
      rstn               = 1'b0;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready     = 1'b0;
      cfg_wvalid         = 1'b0;
      cfg_waddr          = '0;
      cfg_wdata          = '0;
      gvt_ts             = '0;
      accepted           = 0;
      removed            = 0;
      errors             = 0;
      armed              = 1'b0;
      started_m          = 1'b0;
      threshold_m        = int'(RST_SPILL_THRESHOLD);
      margin_m           = RST_THROTTLE_MARGIN;
      prev_margin        = RST_THROTTLE_MARGIN;
      prev_gvt           = '0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      write_cfg(CFG_SPILL_THRESHOLD, 32'd10);
      write_cfg(CFG_SPILL_SIZE, 32'd3);
      write_cfg(CFG_THROTTLE_MARGIN, 32'd200);
      for (int i = 0; i < STIM_CYCLES; i++) begin
         drive_cycle(i);
         @(posedge clk);
         #1;
      end
      // Drain with every ready high and no throttle
      coal_child_valid   = 1'b0;
      task_enq_valid     = 1'b0;
      task_deq_ready     = 1'b1;
      splitter_deq_ready = 1'b1;
      overflow_ready     = 1'b1;
      write_cfg(CFG_THROTTLE_MARGIN, 32'd0);
      while (model.size() != 0) begin
         @(posedge clk);
         #1;
      end
      repeat (2) @(posedge clk);
      #1;
      check_eq(32'(empty), 32'd1, "store not empty after drain");
      check_eq(32'(overflow_valid), 32'd0, "spill FIFO not empty after drain");
      check_eq(lvt, 32'hFFFF_FFFF, "lvt after drain");
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   always @(negedge clk) begin
      if (rstn) begin
         any_ready = coal_child_ready || task_enq_ready;
         check_eq(32'(coal_child_ready && task_enq_ready), 32'd0, "both producer readies high");
         // A ready producer port means the insert register is empty
         if (any_ready) begin
            mark_settled();
         end
         all_settled = settled_all();

         // Model count equals store occupancy here
         if (all_settled && !overflow_valid) begin
            check_eq(32'(empty), 32'(model.size() == 0), "empty flag");
            check_eq(32'(full), 32'(model.size() == TQ_DEPTH), "full flag");
            check_eq(32'(almost_full), 32'(model.size() > threshold_m), "almost_full flag");
            check_eq(lvt, min_ts(), "lvt against the earliest waiting task");
         end

         if (armed) begin
            if (overflow_valid) begin
               armed = 1'b0;
            end else begin
               check_eq(32'(any_ready), 32'd0, "producer ready during a spill burst");
            end
         end
         if (all_settled && !overflow_valid && model.size() > threshold_m) begin
            armed = 1'b1;
         end

         if (!started_m) begin
            check_eq(32'(task_deq_valid), 32'd0, "task dequeue valid before start");
         end

         // A valid overflow port shows a task that has not left yet
         if (overflow_valid) begin
            check_eq(32'(removed < accepted), 32'd1,
                     "overflow valid with no task left in the unit");
         end

         if (task_deq_valid && task_deq_ready) begin
            check_eq(32'(task_deq_data.ttype == TASK_TYPE_SPLITTER), 32'd0,
                     "splitter task at the dequeue port");
            if (prev_margin != '0) begin
               check_eq(32'(task_deq_data.ts < prev_gvt + prev_margin), 32'd1,
                        "dequeued task above the throttle limit");
            end
            if (!overflow_valid) begin
               check_eq(32'(has_earlier_settled(task_deq_data.ts)), 32'd0,
                        "dequeued task later than a waiting task");
            end
            take_task(task_deq_data, "dequeue port");
         end

         if (splitter_deq_valid && splitter_deq_ready) begin
            check_eq(32'(splitter_deq_task.ttype), 32'(TASK_TYPE_SPLITTER),
                     "ordinary task at the splitter port");
            if (!overflow_valid) begin
               check_eq(32'(has_earlier_settled(splitter_deq_task.ts)), 32'd0,
                        "splitter task later than a waiting task");
            end
            take_task(splitter_deq_task, "splitter port");
         end

         if (overflow_valid && overflow_ready) begin
            idx = find_task(overflow_data);
            check_eq(32'(idx >= 0), 32'd1, "overflow port delivered a task never accepted");
            check_eq(32'(older_task_later(idx, overflow_data.ts)), 32'd0,
                     "overflow task earlier than an older waiting task");
            model.delete(idx);
            removed++;
         end

         if (coal_child_valid && coal_child_ready) begin
            model.push_back({1'b0, coal_child_data});
            accepted++;
         end
         if (task_enq_valid && task_enq_ready) begin
            model.push_back({1'b0, task_enq_data});
            accepted++;
         end

         // Throttle register samples gvt and margin one edge later
         prev_gvt    = gvt_ts;
         prev_margin = margin_m;
         if (cfg_wvalid) begin
            case (cfg_waddr)
               CFG_SPILL_THRESHOLD: threshold_m = int'(cfg_wdata[CNT_WIDTH-1:0]);
               CFG_THROTTLE_MARGIN: margin_m = cfg_wdata;
               CFG_START:           started_m = cfg_wdata[0];
               default: begin
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* tq_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_cfg_regs (
   input  wire                                     clk,
   input  wire                                     rstn,
   input  wire                                     cfg_wvalid,
   input  wire [tq_ctrl_pkg::CFG_ADDR_WIDTH-1:0]   cfg_waddr,
   input  wire [31:0]                              cfg_wdata,
   output logic [tq_ctrl_pkg::CNT_WIDTH-1:0]       spill_threshold,
   output logic [tq_ctrl_pkg::CNT_WIDTH-1:0]       spill_size,
   output tq_task_pkg::ts_t                        throttle_margin,
   output logic                                    started
);
   import tq_ctrl_pkg::*;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_threshold <= RST_SPILL_THRESHOLD;
         spill_size      <= RST_SPILL_SIZE;
         throttle_margin <= RST_THROTTLE_MARGIN;
         started         <= 1'b0;
      end else if (cfg_wvalid) begin
         case (cfg_waddr)
            CFG_SPILL_THRESHOLD: begin
               spill_threshold <= cfg_wdata[CNT_WIDTH-1:0];
            end
            CFG_SPILL_SIZE: begin
               spill_size <= cfg_wdata[CNT_WIDTH-1:0];
            end
            CFG_THROTTLE_MARGIN: begin
               throttle_margin <= cfg_wdata;
            end
            CFG_START: begin
               started <= cfg_wdata[0];
            end
            // Other addresses are ignored
            default: begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* tq_ctrl_pkg.sv */
`default_nettype none

package tq_ctrl_pkg;

   localparam int TQ_DEPTH = 16;
   localparam int CNT_WIDTH = 5;
   localparam int SPILL_FIFO_DEPTH = 16;

   // NOP needs the third bit
   typedef enum logic [2:0] {
      ENQ     = 3'b000,
      REPLACE = 3'b001,
      DEQ_MIN = 3'b010,
      DEQ_MAX = 3'b011,
      NOP     = 3'b100
   } heap_op_t;

   localparam int CFG_ADDR_WIDTH = 4;

   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_SPILL_THRESHOLD = 4'd0;
   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_SPILL_SIZE      = 4'd1;
   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_THROTTLE_MARGIN = 4'd2;
   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_START           = 4'd3;

   localparam logic [CNT_WIDTH-1:0] RST_SPILL_THRESHOLD = 5'd12;
   localparam logic [CNT_WIDTH-1:0] RST_SPILL_SIZE      = 5'd4;
   localparam logic [31:0]          RST_THROTTLE_MARGIN = 32'd1000;

endpackage

`default_nettype wire

/* tq_deq_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_deq_gate (
   input  wire                      clk,
   input  wire                      rstn,
   input  wire tq_task_pkg::task_t  head_task,
   input  wire                      head_valid,
   input  wire                      started,
   input  wire                      spilling,
   input  wire tq_task_pkg::ts_t    gvt_ts,
   input  wire tq_task_pkg::ts_t    throttle_margin,
   input  wire                      task_deq_ready,
   input  wire                      splitter_deq_ready,
   output logic                     task_deq_valid,
   output logic                     splitter_deq_valid,
   output tq_task_pkg::task_t       task_deq_data,
   output tq_task_pkg::task_t       splitter_deq_task,
   output logic                     deq_fire,
   output tq_task_pkg::ts_t         lvt
);
   import tq_task_pkg::*;

   ts_t  throttle_ts;
   logic is_splitter;

   // Zero margin lifts the limit
   always_ff @(posedge clk) begin
      if (!rstn) begin
         throttle_ts <= '0;
      end else if (throttle_margin == '0) begin
         throttle_ts <= '1;
      end else begin
         throttle_ts <= gvt_ts + throttle_margin;
      end
   end

   assign is_splitter = (head_task.ttype == TASK_TYPE_SPLITTER);

   assign task_deq_valid = head_valid && !is_splitter && started && !spilling &&
                           (head_task.ts < throttle_ts);
   assign splitter_deq_valid = head_valid && is_splitter && !spilling;

   assign task_deq_data     = head_task;
   assign splitter_deq_task = head_task;

   assign deq_fire = (task_deq_valid && task_deq_ready) ||
                     (splitter_deq_valid && splitter_deq_ready);

   assign lvt = head_valid ? head_task.ts : '1;

endmodule

`default_nettype wire

/* tq_insert_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_insert_stage (
   input  wire                      clk,
   input  wire                      rstn,
   input  wire                      coal_child_valid,
   input  wire tq_task_pkg::task_t  coal_child_data,
   output logic                     coal_child_ready,
   input  wire                      task_enq_valid,
   input  wire tq_task_pkg::task_t  task_enq_data,
   output logic                     task_enq_ready,
   input  wire                      spilling,
   input  wire                      ins_clear,
   output logic                     ins_valid,
   output tq_task_pkg::task_t       ins_task
);
   import tq_task_pkg::*;

   logic  accept;
   task_t accept_task;

   // Coalescer children take priority over new enqueues
   always_comb begin
      coal_child_ready = 1'b0;
      task_enq_ready   = 1'b0;
      if (!ins_valid && !spilling) begin
         if (coal_child_valid) begin
            coal_child_ready = 1'b1;
         end else begin
            task_enq_ready = 1'b1;
         end
      end
   end

   assign accept = (coal_child_valid & coal_child_ready) | (task_enq_valid & task_enq_ready);
   assign accept_task = coal_child_ready ? coal_child_data : task_enq_data;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ins_valid <= 1'b0;
      end else if (accept) begin
         ins_valid <= 1'b1;
      end else if (ins_clear) begin
         ins_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         ins_task <= accept_task;
      end
   end

   a_one_producer: assert property (@(posedge clk) disable iff (!rstn)
      !(coal_child_ready && task_enq_ready));

endmodule

`default_nettype wire

/* tq_op_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_op_sched (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire                                  spilling,
   input  wire                                  ins_valid,
   input  wire                                  deq_fire,
   input  wire                                  empty,
   input  wire                                  full,
   input  wire [tq_ctrl_pkg::CNT_WIDTH-1:0]     fifo_count,
   output tq_ctrl_pkg::heap_op_t                store_op,
   output logic                                 ins_clear
);
   import tq_ctrl_pkg::*;

   typedef enum logic {NORMAL, SPILL} sched_state_t;

   sched_state_t state;
   heap_op_t     last_op;

   always_comb begin
      store_op  = NOP;
      ins_clear = 1'b0;
      if (spilling) begin
         if (!empty && (fifo_count < CNT_WIDTH'(SPILL_FIFO_DEPTH))) begin
            store_op = DEQ_MAX;
         end
      end else if (ins_valid && deq_fire) begin
         store_op  = REPLACE;
         ins_clear = 1'b1;
      end else if (ins_valid && !full) begin
         store_op  = ENQ;
         ins_clear = 1'b1;
      end else if (deq_fire) begin
         store_op = DEQ_MIN;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state   <= NORMAL;
         last_op <= NOP;
      end else begin
         state   <= spilling ? SPILL : NORMAL;
         last_op <= store_op;
      end
   end

   // A spilled task is still in the FIFO one cycle later
   a_spill_landed: assert property (@(posedge clk) disable iff (!rstn)
      ((state == SPILL) && (last_op == DEQ_MAX)) |-> (fifo_count != '0));

endmodule

`default_nettype wire

/* tq_spill_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_spill_counter (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire tq_ctrl_pkg::heap_op_t           store_op,
   input  wire [tq_ctrl_pkg::CNT_WIDTH-1:0]     n_tasks,
   input  wire [tq_ctrl_pkg::CNT_WIDTH-1:0]     spill_threshold,
   input  wire [tq_ctrl_pkg::CNT_WIDTH-1:0]     spill_size,
   output logic                                 almost_full,
   output logic                                 spilling
);
   import tq_ctrl_pkg::*;

   logic [CNT_WIDTH-1:0] spills_remaining;

   assign almost_full = (n_tasks > spill_threshold);
   assign spilling    = (spills_remaining != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spills_remaining <= '0;
      end else if (!spilling && almost_full) begin
         spills_remaining <= spill_size;
      end else if (spilling && (n_tasks == '0)) begin
         // Nothing left to spill
         spills_remaining <= '0;
      end else if (store_op == DEQ_MAX) begin
         spills_remaining <= spills_remaining - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* tq_spill_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_spill_fifo (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire                                  wr_en,
   input  wire tq_task_pkg::task_t              wr_data,
   input  wire                                  overflow_ready,
   output logic                                 overflow_valid,
   output tq_task_pkg::task_t                   overflow_data,
   output logic [tq_ctrl_pkg::CNT_WIDTH-1:0]    fifo_count
);
   import tq_task_pkg::*;
   import tq_ctrl_pkg::*;

   localparam int PTR_W = $clog2(SPILL_FIFO_DEPTH);

   task_t            mem [SPILL_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             rd_en;

   assign overflow_valid = (fifo_count != '0);
   assign overflow_data  = mem[rd_ptr];
   assign rd_en          = overflow_valid && overflow_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap naturally at the power of two depth
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         fifo_count <= fifo_count + CNT_WIDTH'(wr_en) - CNT_WIDTH'(rd_en);
      end
   end

   a_no_write_full: assert property (@(posedge clk) disable iff (!rstn)
      wr_en |-> (fifo_count < CNT_WIDTH'(SPILL_FIFO_DEPTH)));

endmodule

`default_nettype wire

/* tq_task_pkg.sv */
`default_nettype none

package tq_task_pkg;

   localparam int TS_WIDTH = 32;

   typedef logic [TS_WIDTH-1:0] ts_t;

   typedef logic [3:0] ttype_t;

   // Splitter tasks bypass the commit queue
   localparam ttype_t TASK_TYPE_SPLITTER = 4'd15;

   // Timestamp sits in the top bits of the word
   typedef struct packed {
      ts_t         ts;
      ttype_t      ttype;
      logic [31:0] locale;
      logic [31:0] args;
   } task_t;

endpackage

`default_nettype wire

/* tq_task_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_task_store (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire tq_ctrl_pkg::heap_op_t           store_op,
   input  wire tq_task_pkg::task_t              ins_task,
   output tq_task_pkg::task_t                   head_task,
   output tq_task_pkg::task_t                   max_task,
   output logic                                 head_valid,
   output logic [tq_ctrl_pkg::CNT_WIDTH-1:0]    n_tasks,
   output logic                                 full,
   output logic                                 empty
);
   import tq_task_pkg::*;
   import tq_ctrl_pkg::*;

   localparam int IDX_W = $clog2(TQ_DEPTH);

   task_t slots [TQ_DEPTH];
   task_t up    [TQ_DEPTH];
   task_t down  [TQ_DEPTH];

   // le[i+1]: slot i is valid and not later than the new task, le[0] is a sentinel
   logic [TQ_DEPTH+1:0] le;
   logic [IDX_W-1:0]    tail_idx;

   always_comb begin
      le    = '0;
      le[0] = 1'b1;
      for (int i = 0; i < TQ_DEPTH; i++) begin
         le[i+1] = (CNT_WIDTH'(i) < n_tasks) && (slots[i].ts <= ins_task.ts);
      end
   end

   // Neighbours for shifting up on insert and down on head removal
   always_comb begin
      up[0]            = ins_task;
      down[TQ_DEPTH-1] = ins_task;
      for (int i = 1; i < TQ_DEPTH; i++) begin
         up[i]     = slots[i-1];
         down[i-1] = slots[i];
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < TQ_DEPTH; i++) begin
         case (store_op)
            ENQ: begin
               // Equal timestamps stay in arrival order
               if (!le[i+1]) begin
                  slots[i] <= le[i] ? ins_task : up[i];
               end
            end
            DEQ_MIN: begin
               slots[i] <= down[i];
            end
            REPLACE: begin
               if (le[i+2]) begin
                  slots[i] <= down[i];
               end else if ((i == 0) || le[i+1]) begin
                  slots[i] <= ins_task;
               end
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_tasks <= '0;
      end else begin
         case (store_op)
            ENQ:     n_tasks <= n_tasks + 1'b1;
            DEQ_MIN: n_tasks <= n_tasks - 1'b1;
            DEQ_MAX: n_tasks <= n_tasks - 1'b1;
            default: n_tasks <= n_tasks;
         endcase
      end
   end

   // Wraps to the last slot when full
   assign tail_idx   = n_tasks[IDX_W-1:0] - 1'b1;
   assign head_task  = slots[0];
   assign max_task   = slots[tail_idx];
   assign head_valid = (n_tasks != '0);
   assign empty      = (n_tasks == '0);
   assign full       = (n_tasks == CNT_WIDTH'(TQ_DEPTH));

   a_no_enq_full: assert property (@(posedge clk) disable iff (!rstn)
      (store_op == ENQ) |-> !full);

   a_no_remove_empty: assert property (@(posedge clk) disable iff (!rstn)
      (store_op inside {DEQ_MIN, DEQ_MAX, REPLACE}) |-> !empty);

endmodule

`default_nettype wire
